//--- sim.f
+incdir+include
verilog/afifo_pkg.sv
verilog/afifo_ram_if.sv
verilog/afifo_gray_sync.sv
verilog/afifo_dpram.sv
verilog/afifo_wr_ctrl.sv
verilog/afifo_rd_ctrl.sv
verilog/async_fifo.sv
verification/async_fifo_assert.sv
verification/async_fifo_tb.sv

//--- verification/async_fifo_tb.sv
`include "afifo_params.svh"

module async_fifo_tb import afifo_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          WR_HALF_PERIOD = 2;
  localparam int          RD_HALF_PERIOD = 3;
  localparam logic [31:0] SEED           = 32'hd0e0b2c8;
  localparam int          RESET_CYCLES   = 8;    // wr_clk cycles
  localparam int          IDLE_CYCLES    = 8;    // rd_clk cycles
  localparam int          EMPTY_TIMEOUT  = 12;   // rd_clk cycles
  localparam int          DRAIN_TIMEOUT  = `AFIFO_DEPTH * 4 + 20;
  localparam int          SINGLE_WORDS   = 4;

  logic        wr_clk;
  logic        wr_rst_n;
  logic        wr_en;
  afifo_data_t wr_data;
  logic        full;
  logic        afull;
  logic        rd_clk;
  logic        rd_rst_n;
  logic        rd_en;
  afifo_data_t rd_data;
  logic        empty;
  logic        aempty;

  // Reference model
  afifo_data_t model_q [$];
  int          true_count     = 0;
  logic        check_pending  = 1'b0;   // A popped word is due on rd_data
  afifo_data_t expected_word  = '0;
  int          value_errors   = 0;
  int          timeout_errors = 0;
  int          model_errors   = 0;
  int          assert_errors  = 0;
  int          pushed_words   = 0;
  int          popped_words   = 0;
  int          blocked_writes = 0;

  async_fifo u_async_fifo (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .full     (full),
    .afull    (afull),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .empty    (empty),
    .aempty   (aempty)
  );

  initial begin
    wr_clk = 1'b0;
    forever begin
      #WR_HALF_PERIOD wr_clk = ~wr_clk;
    end
  end

  initial begin
    rd_clk = 1'b0;
    forever begin
      #RD_HALF_PERIOD rd_clk = ~rd_clk;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic compare_data(input afifo_data_t actual, input afifo_data_t expected,
                              input string what);
    if (actual !== expected) begin
      value_errors++;
      $display("[ERROR] %0t: %s is %h, expected %h", $realtime, what, actual, expected);
    end
  endtask

  task automatic compare_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      value_errors++;
      $display("[ERROR] %0t: %s is %b, expected %b", $realtime, name, actual, expected);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_errors++;
    $display("Timeout at %0t: %s did not happen in time", $realtime, what);
  endtask

  // Model write side sees the values from before the edge
  always @(posedge wr_clk) begin
    if (wr_rst_n) begin
      if (true_count == `AFIFO_DEPTH) begin
        compare_flag("full at depth", full, 1'b1);
      end
      if (wr_en && full) begin
        blocked_writes++;
      end else if (wr_en) begin
        model_q.push_back(wr_data);
        true_count++;
        pushed_words++;
        if (true_count > `AFIFO_DEPTH) begin
          model_errors++;
          $display("Overflow at %0t: a write was taken with no room left", $realtime);
        end
      end
    end
  end

  // Popped word shows on rd_data one rd_clk later
  always @(posedge rd_clk) begin
    if (rd_rst_n) begin
      if (check_pending) begin
        compare_data(rd_data, expected_word, "rd_data");
        check_pending = 1'b0;
      end
      if (true_count == 0) begin
        compare_flag("empty at zero", empty, 1'b1);
      end
      if (rd_en && !empty) begin
        if (true_count == 0) begin
          model_errors++;
          $display("Underflow at %0t: a read popped a word never written", $realtime);
        end else begin
          expected_word = model_q.pop_front();
          true_count--;
          popped_words++;
          check_pending = 1'b1;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic drive_writes(input int cycles, input int pct);
    for (int i = 0; i < cycles; i++) begin
      @(posedge wr_clk);
      wr_en   <= ($urandom_range(99) < pct);
      wr_data <= afifo_data_t'($urandom);
    end
    @(posedge wr_clk);
    wr_en <= 1'b0;
  endtask

  task automatic drive_reads(input int cycles, input int pct);
    for (int i = 0; i < cycles; i++) begin
      @(posedge rd_clk);
      rd_en <= ($urandom_range(99) < pct);
    end
    @(posedge rd_clk);
    rd_en <= 1'b0;
  endtask

  // Both sides run for about the same time
  task automatic run_traffic(input int wr_cycles, input int wr_pct, input int rd_pct);
    fork
      drive_writes(wr_cycles, wr_pct);
      drive_reads((wr_cycles * 2) / 3, rd_pct);
    join
  endtask

  task automatic check_idle_flags(input string phase);
    repeat (IDLE_CYCLES) @(posedge rd_clk);
    @(negedge rd_clk);
    compare_flag({phase, " afull"}, afull, true_count >= `AFIFO_AFULL);
    compare_flag({phase, " aempty"}, aempty, true_count <= `AFIFO_AEMPTY);
    compare_flag({phase, " full"}, full, true_count == `AFIFO_DEPTH);
    compare_flag({phase, " empty"}, empty, true_count == 0);
  endtask

  task automatic write_single_word();
    @(posedge wr_clk);
    wr_en   <= 1'b1;
    wr_data <= afifo_data_t'($urandom);
    @(posedge wr_clk);
    wr_en   <= 1'b0;
  endtask

  task automatic wait_for_data(input int limit);
    int cycles;
    cycles = 0;
    do begin
      @(negedge rd_clk);
      cycles++;
    end while (empty && cycles < limit);
    if (empty) begin
      report_timeout("empty falling after a write");
    end
  endtask

  // Reads until model, flag and last data check are all done
  task automatic drain_fifo(input int limit);
    int  cycles;
    logic done;
    cycles = 0;
    @(posedge rd_clk);
    rd_en <= 1'b1;
    do begin
      @(negedge rd_clk);
      cycles++;
      done = (true_count == 0) && empty && !check_pending;
    end while (!done && cycles < limit);
    @(posedge rd_clk);
    rd_en <= 1'b0;
    if (!done) begin
      report_timeout("draining the FIFO");
    end
  endtask

  initial begin
    $timeformat(-9, 1, " ns", 0);
    void'($urandom(SEED));
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en    = 1'b0;
    wr_data  = '0;
    rd_en    = 1'b0;
    repeat (RESET_CYCLES) @(posedge wr_clk);
    wr_rst_n <= 1'b1;
    rd_rst_n <= 1'b1;

    @(negedge rd_clk);
    compare_flag("full after reset", full, 1'b0);
    compare_flag("afull after reset", afull, 1'b0);
    compare_flag("empty after reset", empty, 1'b1);
    compare_flag("aempty after reset", aempty, 1'b1);
    compare_data(rd_data, afifo_data_t'(0), "rd_data after reset");

    run_traffic(200, 90, 20);            // Write heavy
    check_idle_flags("write heavy");
    run_traffic(300, 15, 95);            // Read heavy
    check_idle_flags("read heavy");
    run_traffic(400, 50, 60);
    check_idle_flags("balanced");
    run_traffic(40, 100, 0);             // Push on while full
    check_idle_flags("filled");

    drain_fifo(DRAIN_TIMEOUT);
    check_idle_flags("drained");
    for (int k = 0; k < SINGLE_WORDS; k++) begin
      write_single_word();
      wait_for_data(EMPTY_TIMEOUT);
      drain_fifo(DRAIN_TIMEOUT);
    end

    assert_errors = u_async_fifo.u_async_fifo_assert.error_count;
    $display("Errors: %0d value, %0d timeout, %0d model, %0d assertion %s",
             value_errors, timeout_errors, model_errors, assert_errors,
             $sformatf("(%0d written, %0d read, %0d blocked)",
                       pushed_words, popped_words, blocked_writes));
    if (value_errors == 0 && timeout_errors == 0 && model_errors == 0 &&
        assert_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- verification/async_fifo_assert.sv
module async_fifo_assert import afifo_pkg::*; (
  input logic        wr_clk,
  input logic        wr_rst_n,
  input logic        wr_en,
  input afifo_data_t wr_data,
  input logic        full,
  input logic        afull,
  input logic        rd_clk,
  input logic        rd_rst_n,
  input logic        rd_en,
  input afifo_data_t rd_data,
  input logic        empty,
  input logic        aempty
);

  timeunit 1ns;
  timeprecision 100ps;

  int error_count = 0;   // Failed assertions so far

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write domain
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_full_afull: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) full |-> afull
  ) else begin
    error_count++;
    $error("full is set while afull is clear");
  end

  a_wr_data_known: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) wr_en |-> !$isunknown(wr_data)
  ) else begin
    error_count++;
    $error("wr_data has unknown bits during a write");
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read domain
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_empty_aempty: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) empty |-> aempty
  ) else begin
    error_count++;
    $error("empty is set while aempty is clear");
  end

  // Output register only moves on a pop
  a_rd_data_hold: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) !(rd_en && !empty) |=> $stable(rd_data)
  ) else begin
    error_count++;
    $error("rd_data changed without a pop");
  end

endmodule

bind async_fifo async_fifo_assert u_async_fifo_assert (
  .wr_clk   (wr_clk),
  .wr_rst_n (wr_rst_n),
  .wr_en    (wr_en),
  .wr_data  (wr_data),
  .full     (full),
  .afull    (afull),
  .rd_clk   (rd_clk),
  .rd_rst_n (rd_rst_n),
  .rd_en    (rd_en),
  .rd_data  (rd_data),
  .empty    (empty),
  .aempty   (aempty)
);

//--- verilog/async_fifo.sv
module async_fifo import afifo_pkg::*; (
  // Write domain
  input  logic        wr_clk,
  input  logic        wr_rst_n,
  input  logic        wr_en,
  input  afifo_data_t wr_data,
  output logic        full,
  output logic        afull,
  // Read domain
  input  logic        rd_clk,
  input  logic        rd_rst_n,
  input  logic        rd_en,
  output afifo_data_t rd_data,
  output logic        empty,
  output logic        aempty
);

  afifo_ptr_t wr_ptr_gray;
  afifo_ptr_t wr_ptr_gray_sync;   // In rd_clk domain
  afifo_ptr_t rd_ptr_gray;
  afifo_ptr_t rd_ptr_gray_sync;   // In wr_clk domain

  afifo_ram_if u_ram_if ();

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  afifo_wr_ctrl u_wr_ctrl (
    .wr_clk           (wr_clk),
    .wr_rst_n         (wr_rst_n),
    .wr_en            (wr_en),
    .wr_data          (wr_data),
    .rd_ptr_gray_sync (rd_ptr_gray_sync),
    .wr_ptr_gray      (wr_ptr_gray),
    .full             (full),
    .afull            (afull),
    .ram              (u_ram_if.writer)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage and pointer crossing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  afifo_dpram u_dpram (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .ram      (u_ram_if.mem)
  );

  afifo_gray_sync u_wr2rd_sync (
    .clk           (rd_clk),
    .rst_n         (rd_rst_n),
    .ptr_gray      (wr_ptr_gray),
    .ptr_gray_sync (wr_ptr_gray_sync)
  );

  afifo_gray_sync u_rd2wr_sync (
    .clk           (wr_clk),
    .rst_n         (wr_rst_n),
    .ptr_gray      (rd_ptr_gray),
    .ptr_gray_sync (rd_ptr_gray_sync)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  afifo_rd_ctrl u_rd_ctrl (
    .rd_clk           (rd_clk),
    .rd_rst_n         (rd_rst_n),
    .rd_en            (rd_en),
    .wr_ptr_gray_sync (wr_ptr_gray_sync),
    .rd_ptr_gray      (rd_ptr_gray),
    .empty            (empty),
    .aempty           (aempty),
    .ram              (u_ram_if.reader)
  );

  assign rd_data = u_ram_if.rd_data;   // Memory output register

endmodule

//--- verilog/afifo_rd_ctrl.sv
`include "afifo_params.svh"

module afifo_rd_ctrl import afifo_pkg::*; (
  input  logic        rd_clk,
  input  logic        rd_rst_n,
  input  logic        rd_en,
  input  afifo_ptr_t  wr_ptr_gray_sync,   // Already in rd_clk domain
  output afifo_ptr_t  rd_ptr_gray,
  output logic        empty,
  output logic        aempty,
  afifo_ram_if.reader ram
);

  logic         rd_vld;
  afifo_ptr_t   rd_ptr_bin;
  afifo_ptr_t   rd_ptr_nxt;
  afifo_ptr_t   rd_ptr_gray_nxt;
  afifo_ptr_t   wr_ptr_bin_sync;
  afifo_level_t rd_level_nxt;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read pointer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign rd_vld = rd_en && !empty;       // Reads while empty pop nothing

  always_comb begin
    if (rd_vld) begin
      rd_ptr_nxt = rd_ptr_bin + 1'b1;
    end else begin
      rd_ptr_nxt = rd_ptr_bin;
    end
  end

  assign rd_ptr_gray_nxt = bin2gray(rd_ptr_nxt);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr_bin  <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr_bin  <= rd_ptr_nxt;
      rd_ptr_gray <= rd_ptr_gray_nxt;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Memory read port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Current pointer addresses the word being popped
  assign ram.rd_en   = rd_vld;
  assign ram.rd_addr = rd_ptr_bin[`AFIFO_ADDR_WIDTH-1:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign wr_ptr_bin_sync = gray2bin(wr_ptr_gray_sync);

  // Write pointer lags, so the level never overstates the content
  assign rd_level_nxt = wr_ptr_bin_sync - rd_ptr_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= (rd_level_nxt == '0);
      aempty <= (rd_level_nxt <= afifo_level_t'(`AFIFO_AEMPTY));
    end
  end

endmodule

//--- verilog/afifo_wr_ctrl.sv
`include "afifo_params.svh"

module afifo_wr_ctrl import afifo_pkg::*; (
  input  logic        wr_clk,
  input  logic        wr_rst_n,
  input  logic        wr_en,
  input  afifo_data_t wr_data,
  input  afifo_ptr_t  rd_ptr_gray_sync,   // Already in wr_clk domain
  output afifo_ptr_t  wr_ptr_gray,
  output logic        full,
  output logic        afull,
  afifo_ram_if.writer ram
);

  logic         wr_vld;
  afifo_ptr_t   wr_ptr_bin;
  afifo_ptr_t   wr_ptr_nxt;
  afifo_ptr_t   wr_ptr_gray_nxt;
  afifo_ptr_t   rd_ptr_bin_sync;
  afifo_level_t wr_level_nxt;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write pointer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign wr_vld = wr_en && !full;        // Writes while full are dropped

  always_comb begin
    if (wr_vld) begin
      wr_ptr_nxt = wr_ptr_bin + 1'b1;
    end else begin
      wr_ptr_nxt = wr_ptr_bin;
    end
  end

  assign wr_ptr_gray_nxt = bin2gray(wr_ptr_nxt);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr_bin  <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr_bin  <= wr_ptr_nxt;
      wr_ptr_gray <= wr_ptr_gray_nxt;    // Registered, so glitch free
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Memory write port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign ram.wr_en   = wr_vld;
  assign ram.wr_addr = wr_ptr_bin[`AFIFO_ADDR_WIDTH-1:0];
  assign ram.wr_data = wr_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign rd_ptr_bin_sync = gray2bin(rd_ptr_gray_sync);

  // Pessimistic level, the read pointer lags by the sync delay
  assign wr_level_nxt = wr_ptr_nxt - rd_ptr_bin_sync;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= (wr_level_nxt == afifo_level_t'(`AFIFO_DEPTH));
      afull <= (wr_level_nxt >= afifo_level_t'(`AFIFO_AFULL));
    end
  end

endmodule

//--- verilog/afifo_dpram.sv
`include "afifo_params.svh"

module afifo_dpram import afifo_pkg::*; (
  input  logic     wr_clk,
  input  logic     rd_clk,
  input  logic     rd_rst_n,
  afifo_ram_if.mem ram
);

  afifo_data_t mem [`AFIFO_DEPTH];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge wr_clk) begin
    if (ram.wr_en) begin
      mem[ram.wr_addr] <= ram.wr_data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The output register holds the last popped word until the next pop
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      ram.rd_data <= '0;
    end else if (ram.rd_en) begin
      ram.rd_data <= mem[ram.rd_addr];
    end
  end

endmodule

//--- verilog/afifo_gray_sync.sv
`include "afifo_params.svh"

module afifo_gray_sync import afifo_pkg::*; #(
  parameter int STAGES = `AFIFO_SYNC_STAGES
) (
  input  logic       clk,
  input  logic       rst_n,
  input  afifo_ptr_t ptr_gray,       // Source domain, registered Gray
  output afifo_ptr_t ptr_gray_sync
);

  afifo_ptr_t sync_q [STAGES];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= ptr_gray;             // Metastable stage
      for (int i = 1; i < STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign ptr_gray_sync = sync_q[STAGES-1];

endmodule

//--- verilog/afifo_ram_if.sv
interface afifo_ram_if import afifo_pkg::*; ();

  // Write port, wr_clk domain
  logic        wr_en;
  afifo_addr_t wr_addr;
  afifo_data_t wr_data;

  // Read port, rd_clk domain
  logic        rd_en;
  afifo_addr_t rd_addr;
  afifo_data_t rd_data;

  modport writer (
    output wr_en,
    output wr_addr,
    output wr_data
  );

  modport reader (
    output rd_en,
    output rd_addr
  );

  modport mem (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

//--- verilog/afifo_pkg.sv
package afifo_pkg;

  `include "afifo_params.svh"

  typedef logic [`AFIFO_DATA_WIDTH-1:0] afifo_data_t;
  typedef logic [`AFIFO_ADDR_WIDTH-1:0] afifo_addr_t;
  typedef logic [`AFIFO_ADDR_WIDTH:0]   afifo_ptr_t;   // Extra bit for wrap
  typedef logic [`AFIFO_ADDR_WIDTH:0]   afifo_level_t; // 0 up to depth

  // Binary to reflected Gray code
  function automatic afifo_ptr_t bin2gray(input afifo_ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // Gray back to binary, MSB first
  function automatic afifo_ptr_t gray2bin(input afifo_ptr_t gray);
    afifo_ptr_t bin;
    bin[`AFIFO_ADDR_WIDTH] = gray[`AFIFO_ADDR_WIDTH];
    for (int i = `AFIFO_ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

//--- include/afifo_params.svh
`ifndef AFIFO_PARAMS_SVH
`define AFIFO_PARAMS_SVH

// Word and storage geometry
`define AFIFO_DATA_WIDTH 8
`define AFIFO_DEPTH 16   // Power of two only
`define AFIFO_ADDR_WIDTH 4

// Flag thresholds, in words
`define AFIFO_AFULL 14   // Write side, level at or above
`define AFIFO_AEMPTY 2   // Read side, level at or below

// Clock domain crossing
`define AFIFO_SYNC_STAGES 2

`endif
